//--- rtl/rob_pkg.sv
// Reorder buffer shared definitions
// Sizes of the buffer and the dispatch group, the commit id type,
// the lane index type and the exception cause encoding.

package rob_pkg;

  // --------------------
  // sizes
  // --------------------
  localparam int unsigned DISP_SIZE  = 2;   // lanes per dispatch group
  localparam int unsigned ENTRY_NUM  = 8;   // groups held in the buffer
  localparam int unsigned ENTRY_W    = 3;   // entry index width
  localparam int unsigned CMT_ID_W   = 4;   // entry index plus wrap bit
  localparam int unsigned DONE_PORTS = 2;   // completion report ports
  localparam int unsigned XLEN       = 32;  // pc and tval width

  // --------------------
  // types
  // --------------------

  // commit id, msb toggles on every pass through the entries
  typedef logic [CMT_ID_W-1:0] cmt_id_t;

  // lane inside a group
  typedef logic [0:0] lane_t;

  // riscv exception causes seen at commit
  typedef enum logic [3:0] {
    INST_ADDR_MISALIGN = 4'd0,
    INST_ACC_FAULT     = 4'd1,
    ILLEGAL_INST       = 4'd2,
    BREAKPOINT         = 4'd3,
    LOAD_ACC_FAULT     = 4'd5,
    STORE_ACC_FAULT    = 4'd7
  } except_e;

  // --------------------
  // helpers
  // --------------------

  // fetch side faults report the faulting pc as tval
  function automatic logic is_pc_tval(except_e cause);
    return (cause == INST_ADDR_MISALIGN) || (cause == INST_ACC_FAULT);
  endfunction

endpackage

//--- rtl/rob_ctrl.sv
// Reorder buffer control
// Keeps the dispatch (tail) and commit (head) ids, decides when the
// head group retires, returns one credit per commit and raises the
// kill pulse for the entry array on a flushing commit.

`timescale 1ns/1ps

module rob_ctrl (
  input  logic             i_clk,
  input  logic             i_reset_n,

  input  logic             i_disp_valid,   // a group is dispatched this cycle
  input  logic             i_head_done,    // every valid lane of the head is done
  input  logic             i_flush,        // head commit carries a live exception

  output rob_pkg::cmt_id_t o_tail_id,
  output rob_pkg::cmt_id_t o_head_id,
  output logic             o_kill,
  output logic             o_cmt_valid,
  output logic             o_credit_return
);

  rob_pkg::cmt_id_t r_tail_id;
  rob_pkg::cmt_id_t r_head_id;
  logic             w_commit;

  // --------------------
  // id increment
  // --------------------

  // wrap the index at the last entry and toggle the msb
  function automatic rob_pkg::cmt_id_t next_id(rob_pkg::cmt_id_t id);
    rob_pkg::cmt_id_t nxt;
    if (int'(id[rob_pkg::ENTRY_W-1:0]) == rob_pkg::ENTRY_NUM - 1) begin
      nxt = {~id[rob_pkg::CMT_ID_W-1], {rob_pkg::ENTRY_W{1'b0}}};
    end else begin
      nxt = id + rob_pkg::cmt_id_t'(1);
    end
    return nxt;
  endfunction

  // --------------------
  // commit decision
  // --------------------

  // no back-pressure on commit, a done head leaves right away
  assign w_commit = i_head_done;

  assign o_cmt_valid     = w_commit;
  assign o_credit_return = w_commit;      // one credit per retired group
  assign o_kill          = w_commit & i_flush;

  // --------------------
  // pointers
  // --------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail_id <= '0;
    end else if (i_disp_valid) begin
      r_tail_id <= next_id(r_tail_id);
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head_id <= '0;
    end else if (w_commit) begin
      r_head_id <= next_id(r_head_id);
    end
  end

  // killed groups stay in place and drain one per cycle
  assign o_tail_id = r_tail_id;
  assign o_head_id = r_head_id;

endmodule

//--- rtl/rob_entry_array.sv
// Reorder buffer entry storage
// One entry per dispatch group. Loads a group at the tail, absorbs
// completion reports from the execution ports, marks younger groups
// killed on a flush and presents the head entry to the commit logic.

`timescale 1ns/1ps

module rob_entry_array (
  input  logic                            i_clk,
  input  logic                            i_reset_n,

  // dispatch
  input  logic                            i_disp_valid,
  input  logic [rob_pkg::DISP_SIZE-1:0]   i_disp_lane_valid,
  input  logic [rob_pkg::XLEN-1:0]        i_disp_pc,
  input  logic [rob_pkg::DISP_SIZE-1:0]   i_disp_illegal,

  // control
  input  rob_pkg::cmt_id_t                i_tail_id,
  input  rob_pkg::cmt_id_t                i_head_id,
  input  logic                            i_kill,
  input  logic                            i_cmt_valid,

  // completion reports
  input  logic                            i_done_valid       [rob_pkg::DONE_PORTS],
  input  rob_pkg::cmt_id_t                i_done_cmt_id      [rob_pkg::DONE_PORTS],
  input  rob_pkg::lane_t                  i_done_lane        [rob_pkg::DONE_PORTS],
  input  logic                            i_done_except      [rob_pkg::DONE_PORTS],
  input  rob_pkg::except_e                i_done_except_type [rob_pkg::DONE_PORTS],
  input  logic [rob_pkg::XLEN-1:0]        i_done_tval        [rob_pkg::DONE_PORTS],
  input  logic                            i_done_mispredict  [rob_pkg::DONE_PORTS],

  // head read-out
  output logic [rob_pkg::DISP_SIZE-1:0]   o_head_grp,
  output logic [rob_pkg::DISP_SIZE-1:0]   o_head_killed,
  output logic [rob_pkg::XLEN-1:0]        o_head_pc,
  output logic [rob_pkg::DISP_SIZE-1:0]   o_head_except,
  output rob_pkg::except_e                o_head_except_type [rob_pkg::DISP_SIZE],
  output logic [rob_pkg::XLEN-1:0]        o_head_tval        [rob_pkg::DISP_SIZE],
  output logic [rob_pkg::DISP_SIZE-1:0]   o_head_mispredict,
  output logic                            o_head_done
);

  // --------------------
  // entry state
  // --------------------
  logic [rob_pkg::ENTRY_NUM-1:0] r_valid;
  logic [rob_pkg::ENTRY_NUM-1:0] r_id_msb;                      // wrap bit at load
  logic [rob_pkg::DISP_SIZE-1:0] r_grp        [rob_pkg::ENTRY_NUM];
  logic [rob_pkg::DISP_SIZE-1:0] r_done       [rob_pkg::ENTRY_NUM];
  logic [rob_pkg::DISP_SIZE-1:0] r_killed     [rob_pkg::ENTRY_NUM];
  logic [rob_pkg::DISP_SIZE-1:0] r_except     [rob_pkg::ENTRY_NUM];
  logic [rob_pkg::DISP_SIZE-1:0] r_mispredict [rob_pkg::ENTRY_NUM];
  logic [rob_pkg::XLEN-1:0]      r_pc         [rob_pkg::ENTRY_NUM];
  rob_pkg::except_e              r_except_type [rob_pkg::ENTRY_NUM][rob_pkg::DISP_SIZE];
  logic [rob_pkg::XLEN-1:0]      r_tval        [rob_pkg::ENTRY_NUM][rob_pkg::DISP_SIZE];

  logic [rob_pkg::DISP_SIZE-1:0] w_port_hit [rob_pkg::ENTRY_NUM][rob_pkg::DONE_PORTS];
  logic [rob_pkg::DISP_SIZE-1:0] w_rpt_hit  [rob_pkg::ENTRY_NUM];
  logic [rob_pkg::ENTRY_W-1:0]   w_tail_idx;
  logic [rob_pkg::ENTRY_W-1:0]   w_head_idx;

  assign w_tail_idx = i_tail_id[rob_pkg::ENTRY_W-1:0];
  assign w_head_idx = i_head_id[rob_pkg::ENTRY_W-1:0];

  // report match on full commit id and lane, pending lanes only
  always_comb begin
    for (int e = 0; e < rob_pkg::ENTRY_NUM; e++) begin
      w_rpt_hit[e] = '0;
      for (int p = 0; p < rob_pkg::DONE_PORTS; p++) begin
        for (int l = 0; l < rob_pkg::DISP_SIZE; l++) begin
          w_port_hit[e][p][l] = i_done_valid[p] && r_valid[e] && r_grp[e][l] && !r_done[e][l] &&
                                (i_done_cmt_id[p] == {r_id_msb[e], e[rob_pkg::ENTRY_W-1:0]}) &&
                                (int'(i_done_lane[p]) == l);
        end
        w_rpt_hit[e] = w_rpt_hit[e] | w_port_hit[e][p];
      end
    end
  end

  // --------------------
  // valid, done, killed
  // --------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      for (int e = 0; e < rob_pkg::ENTRY_NUM; e++) begin
        r_done[e]   <= '0;
        r_killed[e] <= '0;
      end
    end else begin
      for (int e = 0; e < rob_pkg::ENTRY_NUM; e++) begin
        if (i_disp_valid && (w_tail_idx == e[rob_pkg::ENTRY_W-1:0])) begin
          r_valid[e]  <= 1'b1;  // a group dispatched during a flush is born killed
          r_done[e]   <= i_disp_lane_valid & (i_disp_illegal | {rob_pkg::DISP_SIZE{i_kill}});
          r_killed[e] <= i_disp_lane_valid & {rob_pkg::DISP_SIZE{i_kill}};
        end else if (i_cmt_valid && (w_head_idx == e[rob_pkg::ENTRY_W-1:0])) begin
          r_valid[e] <= 1'b0;
        end else if (i_kill && r_valid[e]) begin
          r_done[e]   <= r_grp[e];
          r_killed[e] <= r_grp[e];
        end else begin
          r_done[e] <= r_done[e] | w_rpt_hit[e];
        end
      end
    end
  end

  // --------------------
  // payload
  // --------------------
  always_ff @(posedge i_clk) begin
    for (int e = 0; e < rob_pkg::ENTRY_NUM; e++) begin
      if (i_disp_valid && (w_tail_idx == e[rob_pkg::ENTRY_W-1:0])) begin
        r_id_msb[e]     <= i_tail_id[rob_pkg::CMT_ID_W-1];
        r_grp[e]        <= i_disp_lane_valid;
        r_pc[e]         <= i_disp_pc;
        r_except[e]     <= i_disp_lane_valid & i_disp_illegal & ~{rob_pkg::DISP_SIZE{i_kill}};
        r_mispredict[e] <= '0;
        for (int l = 0; l < rob_pkg::DISP_SIZE; l++) begin
          r_except_type[e][l] <= rob_pkg::ILLEGAL_INST;
          r_tval[e][l]        <= '0;                         // illegal at decode has no tval
        end
      end else if (i_kill && r_valid[e]) begin
        r_except[e]     <= '0;  // killed groups retire quietly
        r_mispredict[e] <= '0;
      end else begin
        for (int p = 0; p < rob_pkg::DONE_PORTS; p++) begin
          for (int l = 0; l < rob_pkg::DISP_SIZE; l++) begin
            if (w_port_hit[e][p][l]) begin
              r_except[e][l]      <= i_done_except[p];
              r_mispredict[e][l]  <= i_done_mispredict[p];
              r_except_type[e][l] <= i_done_except_type[p];
              r_tval[e][l]        <= i_done_tval[p];
            end
          end
        end
      end
    end
  end

  // --------------------
  // head read-out
  // --------------------
  assign o_head_grp         = r_grp[w_head_idx];
  assign o_head_killed      = r_killed[w_head_idx];
  assign o_head_pc          = r_pc[w_head_idx];
  assign o_head_except      = r_except[w_head_idx];
  assign o_head_except_type = r_except_type[w_head_idx];
  assign o_head_tval        = r_tval[w_head_idx];
  assign o_head_mispredict  = r_mispredict[w_head_idx];

  assign o_head_done = r_valid[w_head_idx] &&
                       (r_id_msb[w_head_idx] == i_head_id[rob_pkg::CMT_ID_W-1]) &&
                       ((r_done[w_head_idx] & r_grp[w_head_idx]) == r_grp[w_head_idx]);

endmodule

//--- rtl/rob_commit_sel.sv
// Reorder buffer commit selection
// Looks at the head group, picks the lowest lane that redirects the
// pc (exception or mispredict), builds the dead lane mask and works
// out cause, epc, tval and whether the commit flushes the pipe.

`timescale 1ns/1ps

module rob_commit_sel (
  input  logic [rob_pkg::DISP_SIZE-1:0] i_head_grp,
  input  logic [rob_pkg::DISP_SIZE-1:0] i_head_killed,
  input  logic [rob_pkg::XLEN-1:0]      i_head_pc,
  input  logic [rob_pkg::DISP_SIZE-1:0] i_head_except,
  input  rob_pkg::except_e              i_head_except_type [rob_pkg::DISP_SIZE],
  input  logic [rob_pkg::XLEN-1:0]      i_head_tval        [rob_pkg::DISP_SIZE],
  input  logic [rob_pkg::DISP_SIZE-1:0] i_head_mispredict,
  input  logic                          i_head_done,

  output logic [rob_pkg::DISP_SIZE-1:0] o_dead,
  output logic                          o_except_valid,
  output rob_pkg::except_e              o_except_type,
  output logic [rob_pkg::XLEN-1:0]      o_epc,
  output logic [rob_pkg::XLEN-1:0]      o_tval,
  output logic                          o_flush
);

  logic [rob_pkg::DISP_SIZE-1:0] w_redirect;   // lanes with exception or mispredict
  logic [rob_pkg::DISP_SIZE-1:0] w_after_sel;  // lanes younger than the selected one
  logic [rob_pkg::XLEN-1:0]      w_lane_off;
  rob_pkg::lane_t                w_sel;
  logic                          w_any;

  // --------------------
  // lane select
  // --------------------

  // scan downwards so the lowest redirecting lane wins
  always_comb begin
    w_redirect = (i_head_except | i_head_mispredict) & i_head_grp;
    w_sel      = '0;
    w_any      = 1'b0;
    for (int l = rob_pkg::DISP_SIZE - 1; l >= 0; l--) begin
      if (w_redirect[l]) begin
        w_sel = rob_pkg::lane_t'(l);
        w_any = 1'b1;
      end
    end
  end

  always_comb begin
    for (int l = 0; l < rob_pkg::DISP_SIZE; l++) begin
      w_after_sel[l] = w_any && (l > int'(w_sel));
    end
  end

  // killed lanes plus everything behind the redirect
  assign o_dead = (i_head_killed | w_after_sel) & i_head_grp;

  // --------------------
  // exception fields
  // --------------------
  assign o_except_valid = i_head_done & w_any & i_head_except[w_sel];
  assign o_except_type  = i_head_except_type[w_sel];

  always_comb begin
    w_lane_off = '0;
    w_lane_off[2 +: $bits(rob_pkg::lane_t)] = w_sel;   // 4 bytes per lane
  end

  assign o_epc  = i_head_pc + w_lane_off;
  assign o_tval = rob_pkg::is_pc_tval(o_except_type) ? o_epc : i_head_tval[w_sel];

  // a dead lane never flushes
  assign o_flush = o_except_valid & ~i_head_killed[w_sel];

endmodule

//--- rtl/rob_top.sv
// Reorder buffer top level
// Two lane dispatch, two completion ports, one group committed per
// cycle in order. Credit based flow control towards dispatch.

`timescale 1ns/1ps

module rob_top (
  input  logic                          i_clk,
  input  logic                          i_reset_n,

  // dispatch
  input  logic                          i_disp_valid,
  input  logic [rob_pkg::DISP_SIZE-1:0] i_disp_lane_valid,
  input  logic [rob_pkg::XLEN-1:0]      i_disp_pc,
  input  logic [rob_pkg::DISP_SIZE-1:0] i_disp_illegal,

  // completion reports
  input  logic                          i_done_valid       [rob_pkg::DONE_PORTS],
  input  rob_pkg::cmt_id_t              i_done_cmt_id      [rob_pkg::DONE_PORTS],
  input  rob_pkg::lane_t                i_done_lane        [rob_pkg::DONE_PORTS],
  input  logic                          i_done_except      [rob_pkg::DONE_PORTS],
  input  rob_pkg::except_e              i_done_except_type [rob_pkg::DONE_PORTS],
  input  logic [rob_pkg::XLEN-1:0]      i_done_tval        [rob_pkg::DONE_PORTS],
  input  logic                          i_done_mispredict  [rob_pkg::DONE_PORTS],

  // commit
  output logic                          o_cmt_valid,
  output rob_pkg::cmt_id_t              o_cmt_id,
  output logic [rob_pkg::DISP_SIZE-1:0] o_cmt_grp,
  output logic [rob_pkg::DISP_SIZE-1:0] o_cmt_dead,
  output logic                          o_cmt_except_valid,
  output rob_pkg::except_e              o_cmt_except_type,
  output logic [rob_pkg::XLEN-1:0]      o_cmt_epc,
  output logic [rob_pkg::XLEN-1:0]      o_cmt_tval,
  output logic                          o_cmt_flush,
  output logic                          o_credit_return
);

  // --------------------
  // internal wires
  // --------------------
  rob_pkg::cmt_id_t              w_tail_id;
  logic                          w_kill;
  logic                          w_head_done;
  logic [rob_pkg::DISP_SIZE-1:0] w_head_killed;
  logic [rob_pkg::XLEN-1:0]      w_head_pc;
  logic [rob_pkg::DISP_SIZE-1:0] w_head_except;
  rob_pkg::except_e              w_head_except_type [rob_pkg::DISP_SIZE];
  logic [rob_pkg::XLEN-1:0]      w_head_tval        [rob_pkg::DISP_SIZE];
  logic [rob_pkg::DISP_SIZE-1:0] w_head_mispredict;

  rob_ctrl u_ctrl (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_disp_valid    (i_disp_valid),
    .i_head_done     (w_head_done),
    .i_flush         (o_cmt_flush),
    .o_tail_id       (w_tail_id),
    .o_head_id       (o_cmt_id),        // head id is the commit id
    .o_kill          (w_kill),
    .o_cmt_valid     (o_cmt_valid),
    .o_credit_return (o_credit_return)
  );

  rob_entry_array u_entries (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_disp_valid       (i_disp_valid),
    .i_disp_lane_valid  (i_disp_lane_valid),
    .i_disp_pc          (i_disp_pc),
    .i_disp_illegal     (i_disp_illegal),
    .i_tail_id          (w_tail_id),
    .i_head_id          (o_cmt_id),
    .i_kill             (w_kill),
    .i_cmt_valid        (o_cmt_valid),
    .i_done_valid       (i_done_valid),
    .i_done_cmt_id      (i_done_cmt_id),
    .i_done_lane        (i_done_lane),
    .i_done_except      (i_done_except),
    .i_done_except_type (i_done_except_type),
    .i_done_tval        (i_done_tval),
    .i_done_mispredict  (i_done_mispredict),
    .o_head_grp         (o_cmt_grp),       // lane mask goes straight out
    .o_head_killed      (w_head_killed),
    .o_head_pc          (w_head_pc),
    .o_head_except      (w_head_except),
    .o_head_except_type (w_head_except_type),
    .o_head_tval        (w_head_tval),
    .o_head_mispredict  (w_head_mispredict),
    .o_head_done        (w_head_done)
  );

  rob_commit_sel u_commit_sel (
    .i_head_grp         (o_cmt_grp),
    .i_head_killed      (w_head_killed),
    .i_head_pc          (w_head_pc),
    .i_head_except      (w_head_except),
    .i_head_except_type (w_head_except_type),
    .i_head_tval        (w_head_tval),
    .i_head_mispredict  (w_head_mispredict),
    .i_head_done        (w_head_done),
    .o_dead             (o_cmt_dead),
    .o_except_valid     (o_cmt_except_valid),
    .o_except_type      (o_cmt_except_type),
    .o_epc              (o_cmt_epc),
    .o_tval             (o_cmt_tval),
    .o_flush            (o_cmt_flush)
  );

endmodule

//--- bench/tb_clkgen.sv
// Testbench clock and reset generator
// 4 ns clock, active low reset held for the first 5 cycles

`timescale 1ns/1ps

module tb_clkgen (
  output logic o_clk,
  output logic o_reset_n
);

  initial o_clk = 1'b0;
  always #2 o_clk = ~o_clk;   // 4 ns period

  initial begin
    o_reset_n = 1'b0;
    repeat (5) @(posedge o_clk);
    #1 o_reset_n = 1'b1;      // released like any other input
  end

endmodule

//--- bench/rob_chk.sv
// Reorder buffer port checks
// Concurrent assertions on the commit side of the top level,
// bound into every rob_top instance

`timescale 1ns/1ps

module rob_chk (
  input logic                          i_clk,
  input logic                          i_reset_n,
  input logic                          i_cmt_valid,
  input logic [rob_pkg::DISP_SIZE-1:0] i_cmt_grp,
  input logic [rob_pkg::DISP_SIZE-1:0] i_cmt_dead,
  input logic                          i_cmt_except_valid,
  input logic                          i_cmt_flush,
  input logic                          i_credit_return
);

  // one credit per retired group
  a_credit_eq_commit: assert property (@(posedge i_clk) i_credit_return == i_cmt_valid)
    else $error("credit return differs from commit valid");

  a_dead_in_grp: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_cmt_valid |-> ((i_cmt_dead & ~i_cmt_grp) == '0))
    else $error("dead lanes outside the group mask");

  a_flush_has_except: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_cmt_flush |-> i_cmt_except_valid)
    else $error("flush without an exception");

  // quiet commit side while reset is held
  a_reset_quiet: assert property (@(posedge i_clk)
    !i_reset_n |-> (!i_cmt_valid && !i_cmt_flush))
    else $error("commit or flush active during reset");

endmodule

bind rob_top rob_chk u_chk (
  .i_clk              (i_clk),
  .i_reset_n          (i_reset_n),
  .i_cmt_valid        (o_cmt_valid),
  .i_cmt_grp          (o_cmt_grp),
  .i_cmt_dead         (o_cmt_dead),
  .i_cmt_except_valid (o_cmt_except_valid),
  .i_cmt_flush        (o_cmt_flush),
  .i_credit_return    (o_credit_return)
);

//--- bench/rob_tb.sv
// Reorder buffer testbench
// Drives dispatch groups and completion reports, keeps a reference
// queue of outstanding groups and checks every commit against it

`timescale 1ns/1ps

module rob_tb;

  // --------------------
  // run length
  // --------------------
  localparam int LEN_ORDER   = 60;
  localparam int LEN_ILLEGAL = 10;
  localparam int LEN_EXCEPT  = 60;
  localparam int LEN_MISP    = 15;
  localparam int LEN_FLUSH   = 50;
  localparam int LEN_CREDIT  = 10;
  localparam int TIMEOUT = 4 * (LEN_ORDER + LEN_ILLEGAL + LEN_EXCEPT + LEN_MISP +
                                LEN_FLUSH + LEN_CREDIT);

  typedef struct {
    rob_pkg::cmt_id_t id;
    logic [31:0]      pc;
    logic [1:0]       grp;
    logic [1:0]       done;
    logic [1:0]       killed;
    logic [1:0]       exc;
    logic [1:0]       mis;
    rob_pkg::except_e cause [2];
    logic [31:0]      tval [2];
  } grp_rec_t;

  logic clk;
  logic reset_n;

  logic                  disp_valid;
  logic [1:0]            disp_lane_valid;
  logic [31:0]           disp_pc;
  logic [1:0]            disp_illegal;
  logic                  done_valid       [rob_pkg::DONE_PORTS];
  rob_pkg::cmt_id_t      done_cmt_id      [rob_pkg::DONE_PORTS];
  rob_pkg::lane_t        done_lane        [rob_pkg::DONE_PORTS];
  logic                  done_except      [rob_pkg::DONE_PORTS];
  rob_pkg::except_e      done_except_type [rob_pkg::DONE_PORTS];
  logic [31:0]           done_tval        [rob_pkg::DONE_PORTS];
  logic                  done_mispredict  [rob_pkg::DONE_PORTS];

  logic                  cmt_valid;
  rob_pkg::cmt_id_t      cmt_id;
  logic [1:0]            cmt_grp;
  logic [1:0]            cmt_dead;
  logic                  cmt_except_valid;
  rob_pkg::except_e      cmt_except_type;
  logic [31:0]           cmt_epc;
  logic [31:0]           cmt_tval;
  logic                  cmt_flush;
  logic                  credit_return;

  grp_rec_t         model_q[$];
  rob_pkg::cmt_id_t model_tail;
  rob_pkg::cmt_id_t disp_id;
  logic [31:0]      next_pc;
  int               seed;
  int               errors;
  int               commits;
  int               credits;
  int               outstanding;
  int               cycles;
  int               tests;
  string            cur_test;

  tb_clkgen u_clkgen (.o_clk(clk), .o_reset_n(reset_n));

  rob_top DUT (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_disp_valid (disp_valid), .i_disp_lane_valid (disp_lane_valid),
    .i_disp_pc (disp_pc), .i_disp_illegal (disp_illegal),
    .i_done_valid (done_valid), .i_done_cmt_id (done_cmt_id),
    .i_done_lane (done_lane), .i_done_except (done_except),
    .i_done_except_type (done_except_type), .i_done_tval (done_tval),
    .i_done_mispredict (done_mispredict),
    .o_cmt_valid (cmt_valid), .o_cmt_id (cmt_id), .o_cmt_grp (cmt_grp),
    .o_cmt_dead (cmt_dead), .o_cmt_except_valid (cmt_except_valid),
    .o_cmt_except_type (cmt_except_type), .o_cmt_epc (cmt_epc),
    .o_cmt_tval (cmt_tval), .o_cmt_flush (cmt_flush),
    .o_credit_return (credit_return)
  );

  // --------------------
  // helpers
  // --------------------
  task automatic check(input string field, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("Fail %s: %s expected %h actual %h", cur_test, field, exp, act);
      errors++;
    end
  endtask

  // advance to 1 ns after the next edge and drop all strobes
  task automatic tick();
    @(posedge clk);
    #1;
    disp_valid      = 1'b0;
    disp_lane_valid = '0;
    disp_illegal    = '0;
    for (int p = 0; p < rob_pkg::DONE_PORTS; p++) begin
      done_valid[p]      = 1'b0;
      done_except[p]     = 1'b0;
      done_mispredict[p] = 1'b0;
    end
  endtask

  task automatic set_dispatch(input logic [1:0] lanes, input logic [1:0] ill,
                              output rob_pkg::cmt_id_t id);
    while (outstanding >= rob_pkg::ENTRY_NUM) tick();   // out of credits
    disp_valid      = 1'b1;
    disp_lane_valid = lanes;
    disp_illegal    = ill;
    disp_pc         = next_pc;
    id              = disp_id;
    disp_id         = disp_id + 1'b1;   // index plus wrap bit, 8 entries
    next_pc         = next_pc + 32'h40;
    outstanding++;
  endtask

  task automatic set_report(input int p, input rob_pkg::cmt_id_t id, input int lane,
                            input logic exc, input rob_pkg::except_e cause,
                            input logic [31:0] tval, input logic mis);
    done_valid[p]       = 1'b1;
    done_cmt_id[p]      = id;
    done_lane[p]        = rob_pkg::lane_t'(lane);
    done_except[p]      = exc;
    done_except_type[p] = cause;
    done_tval[p]        = tval;
    done_mispredict[p]  = mis;
  endtask

  task automatic wait_drain();
    while (model_q.size() != 0) tick();
    tick();
  endtask

  task automatic end_test();
    tests++;
    $display("test %s finished, errors so far %0d", cur_test, errors);
  endtask

  // --------------------
  // reference model
  // --------------------
  always @(negedge clk) begin : model_step
    grp_rec_t    h;
    grp_rec_t    n;
    logic        exp_valid;
    logic        any;
    logic        ev;
    logic        kill;
    int          sel;
    logic [1:0]  dead;
    logic [31:0] epc;
    logic [31:0] tval;
    if (!reset_n) begin
      check("reset cmt_valid", 0, cmt_valid);
      check("reset cmt_flush", 0, cmt_flush);
    end else begin
      kill      = 1'b0;
      exp_valid = (model_q.size() > 0) && ((model_q[0].done & model_q[0].grp) == model_q[0].grp);
      check("cmt_valid", exp_valid, cmt_valid);
      if (credit_return) begin
        credits++;
        outstanding--;
      end
      if (exp_valid && cmt_valid) begin
        h = model_q.pop_front();
        commits++;
        sel = 0;
        any = 1'b0;
        for (int l = 1; l >= 0; l--) begin
          if (h.grp[l] && (h.exc[l] || h.mis[l])) begin
            sel = l;
            any = 1'b1;
          end
        end
        dead = h.killed;
        for (int l = 0; l < 2; l++) begin
          if (any && l > sel) begin
            dead[l] = 1'b1;
          end
        end
        dead = dead & h.grp;
        ev   = any && h.exc[sel];
        epc  = h.pc + 32'(4 * sel);
        tval = (h.cause[sel] == rob_pkg::INST_ADDR_MISALIGN ||
                h.cause[sel] == rob_pkg::INST_ACC_FAULT) ? epc : h.tval[sel];
        kill = ev && !h.killed[sel];
        check("cmt_id", 32'(h.id), 32'(cmt_id));
        check("cmt_grp", 32'(h.grp), 32'(cmt_grp));
        check("cmt_dead", 32'(dead), 32'(cmt_dead));
        check("cmt_except_valid", 32'(ev), 32'(cmt_except_valid));
        check("cmt_flush", 32'(kill), 32'(cmt_flush));
        if (ev) begin
          check("cmt_except_type", 32'(h.cause[sel]), 32'(cmt_except_type));
          check("cmt_epc", epc, cmt_epc);
          check("cmt_tval", tval, cmt_tval);
        end
      end
      if (disp_valid) begin
        n.id     = model_tail;
        n.pc     = disp_pc;
        n.grp    = disp_lane_valid;
        n.done   = disp_lane_valid & disp_illegal;   // illegal lanes need no report
        n.exc    = disp_lane_valid & disp_illegal;
        n.killed = '0;
        n.mis    = '0;
        for (int l = 0; l < 2; l++) begin
          n.cause[l] = rob_pkg::ILLEGAL_INST;
          n.tval[l]  = '0;
        end
        model_q.push_back(n);
        model_tail = model_tail + 1'b1;
      end
      for (int p = 0; p < rob_pkg::DONE_PORTS; p++) begin
        for (int i = 0; i < model_q.size(); i++) begin
          if (done_valid[p] && model_q[i].id == done_cmt_id[p] &&
              model_q[i].grp[done_lane[p]] && !model_q[i].done[done_lane[p]]) begin
            model_q[i].done[done_lane[p]]  = 1'b1;
            model_q[i].exc[done_lane[p]]   = done_except[p];
            model_q[i].mis[done_lane[p]]   = done_mispredict[p];
            model_q[i].cause[done_lane[p]] = done_except_type[p];
            model_q[i].tval[done_lane[p]]  = done_tval[p];
          end
        end
      end
      if (kill) begin   // younger groups drain dead
        for (int i = 0; i < model_q.size(); i++) begin
          model_q[i].killed = model_q[i].grp;
          model_q[i].done   = model_q[i].grp;
          model_q[i].exc    = '0;
          model_q[i].mis    = '0;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, the DUT stopped committing", cycles);
      $display("sim failed");
      $finish;
    end
  end

  // --------------------
  // tests
  // --------------------
  initial begin : stimulus
    rob_pkg::cmt_id_t ids [8];
    rob_pkg::cmt_id_t pend_id[$];
    int               pend_lane[$];
    rob_pkg::cmt_id_t tmp_id;
    rob_pkg::cmt_id_t a_id;
    rob_pkg::cmt_id_t b_id;
    rob_pkg::cmt_id_t c_id;
    rob_pkg::except_e causes [4];
    logic [1:0]       lanes;
    int               j;
    int               tmp_lane;
    seed        = 32'hb042_7c23;
    errors      = 0;
    commits     = 0;
    credits     = 0;
    outstanding = 0;
    cycles      = 0;
    tests       = 0;
    model_tail = '0;
    disp_id    = '0;
    next_pc    = 32'h8000_0000;
    disp_valid      = 1'b0;
    disp_lane_valid = '0;
    disp_illegal    = '0;
    disp_pc         = '0;
    for (int p = 0; p < rob_pkg::DONE_PORTS; p++) begin
      done_valid[p]       = 1'b0;
      done_except[p]      = 1'b0;
      done_mispredict[p]  = 1'b0;
      done_cmt_id[p]      = '0;
      done_lane[p]        = '0;
      done_except_type[p] = rob_pkg::INST_ADDR_MISALIGN;
      done_tval[p]        = '0;
    end
    cur_test = "reset";
    tick();
    @(posedge reset_n);
    end_test();

    cur_test = "in_order";
    for (int g = 0; g < 8; g++) begin
      lanes = {1'($random(seed)), 1'b1};
      set_dispatch(lanes, 2'b00, ids[g]);
      for (int l = 0; l < 2; l++) begin
        if (lanes[l]) begin
          pend_id.push_back(ids[g]);
          pend_lane.push_back(l);
        end
      end
      tick();
    end
    for (int i = pend_id.size() - 1; i > 0; i--) begin   // shuffle completion order
      j = int'($unsigned($random(seed)) % (i + 1));
      tmp_id       = pend_id[i];
      pend_id[i]   = pend_id[j];
      pend_id[j]   = tmp_id;
      tmp_lane     = pend_lane[i];
      pend_lane[i] = pend_lane[j];
      pend_lane[j] = tmp_lane;
    end
    while (pend_id.size() != 0) begin
      for (int p = 0; p < 2; p++) begin
        if (pend_id.size() != 0 && (p == 0 || $random(seed) % 2 != 0)) begin
          set_report(p, pend_id.pop_front(), pend_lane.pop_front(), 1'b0,
                     rob_pkg::INST_ADDR_MISALIGN, '0, 1'b0);
        end
      end
      tick();
    end
    wait_drain();
    end_test();

    cur_test = "illegal_dispatch";
    set_dispatch(2'b11, 2'b11, tmp_id);
    tick();
    wait_drain();
    end_test();

    cur_test = "reported_exception";
    causes = '{rob_pkg::INST_ACC_FAULT, rob_pkg::BREAKPOINT,
               rob_pkg::LOAD_ACC_FAULT, rob_pkg::STORE_ACC_FAULT};
    for (int k = 0; k < 4; k++) begin
      tmp_lane = (k == 0) ? 1 : 0;
      set_dispatch(2'b11, 2'b00, tmp_id);
      tick();
      set_report(0, tmp_id, tmp_lane, 1'b1, causes[k], $random(seed), 1'b0);
      set_report(1, tmp_id, 1 - tmp_lane, 1'b0, rob_pkg::INST_ADDR_MISALIGN, '0, 1'b0);
      tick();
      wait_drain();
    end
    end_test();

    cur_test = "mispredict";
    set_dispatch(2'b11, 2'b00, tmp_id);
    tick();
    set_report(0, tmp_id, 0, 1'b0, rob_pkg::INST_ADDR_MISALIGN, '0, 1'b1);
    set_report(1, tmp_id, 1, 1'b0, rob_pkg::INST_ADDR_MISALIGN, '0, 1'b0);
    tick();
    wait_drain();
    end_test();

    cur_test = "flush_drain";
    set_dispatch(2'b11, 2'b00, a_id);
    tick();
    set_dispatch(2'b11, 2'b00, b_id);
    tick();
    set_dispatch(2'b11, 2'b00, c_id);
    tick();
    set_report(0, b_id, 0, 1'b0, rob_pkg::INST_ADDR_MISALIGN, '0, 1'b0);
    set_report(1, b_id, 1, 1'b0, rob_pkg::INST_ADDR_MISALIGN, '0, 1'b0);
    tick();
    set_report(0, c_id, 0, 1'b0, rob_pkg::INST_ADDR_MISALIGN, '0, 1'b0);
    tick();
    set_report(0, a_id, 0, 1'b1, rob_pkg::STORE_ACC_FAULT, 32'h1234_5678, 1'b0);
    set_report(1, a_id, 1, 1'b0, rob_pkg::INST_ADDR_MISALIGN, '0, 1'b0);
    tick();
    set_dispatch(2'b11, 2'b00, tmp_id);   // lands in the flush cycle
    tick();
    wait_drain();
    set_dispatch(2'b11, 2'b00, tmp_id);
    tick();
    set_report(0, tmp_id, 0, 1'b0, rob_pkg::INST_ADDR_MISALIGN, '0, 1'b0);
    set_report(1, tmp_id, 1, 1'b0, rob_pkg::INST_ADDR_MISALIGN, '0, 1'b0);
    tick();
    wait_drain();
    end_test();

    cur_test = "credits";
    check("credit count", 32'(commits), 32'(credits));
    end_test();

    $display("tests %0d commits %0d credits %0d errors %0d", tests, commits, credits, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
rtl/rob_pkg.sv
rtl/rob_ctrl.sv
rtl/rob_entry_array.sv
rtl/rob_commit_sel.sv
rtl/rob_top.sv
bench/tb_clkgen.sv
bench/rob_chk.sv
bench/rob_tb.sv

//--- Makefile
# Verilator build and run for the reorder buffer testbench

VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TOP        ?= rob_tb
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall
PASS_MSG   ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
